/* flist.f */
logic/tileCachePkg.sv
logic/tileStore.sv
logic/tileRequestStage.sv
logic/tileFillEngine.sv
logic/l2TileCache.sv
verification/ddrTileModel.sv
verification/l2TileCache_sva.sv
verification/l2TileCacheTb.sv

/* logic/l2TileCache.sv */
`timescale 1ns/1ps
`default_nettype none

module l2TileCache
	import tileCachePkg::*;
(
	input  wire logic                    clock,
	input  wire logic                    reset,

	// requester side
	input  wire logic [addrBits-1:0]     memAddr,
	input  wire logic [tileDataBits-1:0] memDataIn,
	input  wire memOpm_e                 memOpm,
	output logic [tileDataBits-1:0]      memDataOut,
	output memOk_e                       memOk,

	// DDR side
	output logic [addrBits-1:0]          ddrAddr,
	output logic [tileDataBits-1:0]      ddrDataOut,
	output memOpm_e                      ddrOpm,
	input  wire logic [tileDataBits-1:0] ddrDataIn,
	input  wire memOk_e                  ddrOk
);

	logic [tileIndexBits-1:0] readIndex;
	tileLine_s                readLine;
	tileWrite_s               storeWrite;
	fillRequest_s             fillRequest;
	fillResult_s              fillResult;

	tileRequestStage i_tileRequestStage
	(
		.clock       (clock),
		.reset       (reset),
		.memAddr     (memAddr),
		.memDataIn   (memDataIn),
		.memOpm      (memOpm),
		.readLine    (readLine),
		.fillResult  (fillResult),
		.readIndex   (readIndex),
		.storeWrite  (storeWrite),
		.fillRequest (fillRequest),
		.memDataOut  (memDataOut),
		.memOk       (memOk)
	);

	tileFillEngine i_tileFillEngine
	(
		.clock       (clock),
		.reset       (reset),
		.fillRequest (fillRequest),
		.ddrDataIn   (ddrDataIn),
		.ddrOk       (ddrOk),
		.fillResult  (fillResult),
		.ddrAddr     (ddrAddr),
		.ddrDataOut  (ddrDataOut),
		.ddrOpm      (ddrOpm)
	);

	tileStore i_tileStore
	(
		.clock      (clock),
		.readIndex  (readIndex),
		.storeWrite (storeWrite),
		.readLine   (readLine)
	);

endmodule

`default_nettype wire

/* logic/tileCachePkg.sv */
`default_nettype none

package tileCachePkg;

	// address geometry
	localparam int addrBits       = 32;
	localparam int tileOffsetBits = 4;
	localparam int tileIndexBits  = 10;
	localparam int tileTagBits    = addrBits - tileIndexBits - tileOffsetBits;
	localparam int tileLines      = 1 << tileIndexBits;

	// one tile is 128 bits
	localparam int tileDataBits = 128;

	// operation codes, shared by the requester and DDR ports
	typedef enum logic [4:0]
	{
		OPM_READY   = 5'b00000,
		OPM_RD_TILE = 5'b01111,
		OPM_WR_TILE = 5'b10111
	} memOpm_e;

	// status codes
	typedef enum logic [1:0]
	{
		OK_READY = 2'b00,
		OK_OK    = 2'b01,
		OK_HOLD  = 2'b10
	} memOk_e;

	typedef struct packed
	{
		logic [tileTagBits-1:0]    tag;
		logic [tileIndexBits-1:0]  index;
		logic [tileOffsetBits-1:0] offset;
	} tileAddrFields_s;

	// byte address, or the same word split into tag, index and offset
	typedef union packed
	{
		logic [addrBits-1:0] raw;
		tileAddrFields_s     fields;
	} tileAddr_u;

	// one store entry, 148 bits
	typedef struct packed
	{
		logic                    valid;
		logic                    dirty;
		logic [tileTagBits-1:0]  tag;
		logic [tileDataBits-1:0] data;
	} tileLine_s;

	typedef struct packed
	{
		logic                     enable;
		logic [tileIndexBits-1:0] index;
		tileLine_s                line;
	} tileWrite_s;

	// miss hand-off to the fill engine
	typedef struct packed
	{
		logic                    start;
		logic                    victimDirty;
		logic [addrBits-1:0]     victimAddr;
		logic [tileDataBits-1:0] victimData;
		logic [addrBits-1:0]     fillAddr;
	} fillRequest_s;

	// fetched tile, held after the done pulse
	typedef struct packed
	{
		logic                    done;
		logic [addrBits-1:0]     addr;
		logic [tileDataBits-1:0] data;
	} fillResult_s;

endpackage

`default_nettype wire

/* logic/tileFillEngine.sv */
`timescale 1ns/1ps
`default_nettype none

module tileFillEngine
	import tileCachePkg::*;
(
	input  wire logic                    clock,
	input  wire logic                    reset,
	input  wire fillRequest_s            fillRequest,
	input  wire logic [tileDataBits-1:0] ddrDataIn,
	input  wire memOk_e                  ddrOk,
	output fillResult_s                  fillResult,
	output logic [addrBits-1:0]          ddrAddr,
	output logic [tileDataBits-1:0]      ddrDataOut,
	output memOpm_e                      ddrOpm
);

	typedef enum logic [2:0]
	{
		FILL_IDLE,
		FILL_WB_ISSUE,
		FILL_WB_WAIT,
		FILL_RD_ISSUE,
		FILL_RD_WAIT
	} fillState_e;

	fillState_e state;

	// local copy of the miss, kept for the whole sequence
	logic [addrBits-1:0]     victimAddr;
	logic [tileDataBits-1:0] victimData;
	logic [addrBits-1:0]     fillAddr;

	logic                    done;
	logic [addrBits-1:0]     resultAddr;
	logic [tileDataBits-1:0] resultData;

	logic ddrReady;
	logic ddrDone;
	logic accept;

	assign ddrReady = (ddrOk == OK_READY);
	assign ddrDone  = (ddrOk == OK_OK);
	assign accept   = (state == FILL_IDLE) && fillRequest.start;

	assign fillResult = '{done: done, addr: resultAddr, data: resultData};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state  <= FILL_IDLE;
			ddrOpm <= OPM_READY;
			done   <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				FILL_IDLE:
					if (fillRequest.start)
						state <= fillRequest.victimDirty ? FILL_WB_ISSUE : FILL_RD_ISSUE;
				// only raise the opcode while the DDR side is idle
				FILL_WB_ISSUE:
					if (ddrReady)
					begin
						ddrOpm <= OPM_WR_TILE;
						state  <= FILL_WB_WAIT;
					end
				// HOLD keeps everything as is
				FILL_WB_WAIT:
					if (ddrDone)
					begin
						ddrOpm <= OPM_READY;
						state  <= FILL_RD_ISSUE;
					end
				FILL_RD_ISSUE:
					if (ddrReady)
					begin
						ddrOpm <= OPM_RD_TILE;
						state  <= FILL_RD_WAIT;
					end
				FILL_RD_WAIT:
					if (ddrDone)
					begin
						ddrOpm <= OPM_READY;
						done   <= 1'b1;
						state  <= FILL_IDLE;
					end
				default:
				begin
					ddrOpm <= OPM_READY;
					state  <= FILL_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			victimAddr <= fillRequest.victimAddr;
			victimData <= fillRequest.victimData;
			fillAddr   <= fillRequest.fillAddr;
		end

		if ((state == FILL_WB_ISSUE) && ddrReady)
		begin
			ddrAddr    <= victimAddr;
			ddrDataOut <= victimData;
		end
		else if ((state == FILL_RD_ISSUE) && ddrReady)
			ddrAddr <= fillAddr;

		// fetched tile stays put until the next fill
		if ((state == FILL_RD_WAIT) && ddrDone)
		begin
			resultAddr <= fillAddr;
			resultData <= ddrDataIn;
		end
	end

endmodule

`default_nettype wire

/* logic/tileRequestStage.sv */
`timescale 1ns/1ps
`default_nettype none

module tileRequestStage
	import tileCachePkg::*;
(
	input  wire logic                     clock,
	input  wire logic                     reset,
	input  wire tileAddr_u                memAddr,
	input  wire logic [tileDataBits-1:0]  memDataIn,
	input  wire memOpm_e                  memOpm,
	input  wire tileLine_s                readLine,
	input  wire fillResult_s              fillResult,
	output logic [tileIndexBits-1:0]      readIndex,
	output tileWrite_s                    storeWrite,
	output fillRequest_s                  fillRequest,
	output logic [tileDataBits-1:0]       memDataOut,
	output memOk_e                        memOk
);

	typedef enum logic [2:0]
	{
		REQ_SWEEP,
		REQ_IDLE,
		REQ_READ,
		REQ_COMPARE,
		REQ_WAIT_FILL,
		REQ_WRITE_FILL,
		REQ_RELEASE
	} reqState_e;

	reqState_e state;
	reqState_e nextState;

	logic [tileIndexBits-1:0] sweepIndex;

	// captured request
	tileAddr_u               reqAddr;
	logic [tileDataBits-1:0] reqData;
	memOpm_e                 reqOpm;

	tileAddr_u victimAddr;
	tileAddr_u filledAddr;
	logic      hit;
	logic      miss;

	assign readIndex  = reqAddr.fields.index;
	assign memDataOut = readLine.data;
	assign filledAddr = fillResult.addr;

	assign hit  = readLine.valid && (readLine.tag == reqAddr.fields.tag);
	assign miss = (state == REQ_COMPARE) && !hit;

	// victim lives at the same index under the stored tag
	always_comb
	begin
		victimAddr.fields = '{tag: readLine.tag, index: reqAddr.fields.index, offset: '0};
	end

	always_comb
	begin
		if (memOpm == OPM_READY)
			memOk = OK_READY;
		else if ((state == REQ_COMPARE) && hit)
			memOk = OK_OK;
		else
			memOk = OK_HOLD;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			REQ_SWEEP:
				if (sweepIndex == '1)
					nextState = REQ_IDLE;
			REQ_IDLE:
				if (memOpm != OPM_READY)
					nextState = REQ_READ;
			REQ_READ:
				nextState = REQ_COMPARE;
			REQ_COMPARE:
				nextState = hit ? REQ_RELEASE : REQ_WAIT_FILL;
			REQ_WAIT_FILL:
				if (fillResult.done)
					nextState = REQ_WRITE_FILL;
			// filled line is written, then looked up again as a hit
			REQ_WRITE_FILL:
				nextState = REQ_READ;
			REQ_RELEASE:
				if (memOpm == OPM_READY)
					nextState = REQ_IDLE;
			default:
				nextState = REQ_IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state      <= REQ_SWEEP;
			sweepIndex <= '0;
		end
		else
		begin
			state <= nextState;
			if (state == REQ_SWEEP)
				sweepIndex <= sweepIndex + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == REQ_IDLE)
		begin
			reqAddr <= memAddr;
			reqData <= memDataIn;
			reqOpm  <= memOpm;
		end
	end

	// single store write: sweep, fill, or write hit
	always_comb
	begin
		storeWrite = '0;
		case (state)
			REQ_SWEEP:
			begin
				storeWrite.enable = 1'b1;
				storeWrite.index  = sweepIndex;
			end
			REQ_WRITE_FILL:
			begin
				storeWrite.enable = 1'b1;
				storeWrite.index  = filledAddr.fields.index;
				storeWrite.line   = '{valid: 1'b1, dirty: 1'b0,
					tag: filledAddr.fields.tag, data: fillResult.data};
			end
			REQ_COMPARE:
				if (hit && (reqOpm == OPM_WR_TILE))
				begin
					storeWrite.enable = 1'b1;
					storeWrite.index  = reqAddr.fields.index;
					storeWrite.line   = '{valid: 1'b1, dirty: 1'b1,
						tag: reqAddr.fields.tag, data: reqData};
				end
			default:
				storeWrite = '0;
		endcase
	end

	// start pulses the cycle after the miss is seen
	always_ff @(posedge clock)
	begin
		if (reset)
			fillRequest.start <= 1'b0;
		else
		begin
			fillRequest.start <= miss;
			if (miss)
			begin
				fillRequest.victimDirty <= readLine.valid && readLine.dirty;
				fillRequest.victimAddr  <= victimAddr.raw;
				fillRequest.victimData  <= readLine.data;
				fillRequest.fillAddr    <= {reqAddr.raw[addrBits-1:tileOffsetBits],
					{tileOffsetBits{1'b0}}};
			end
		end
	end

endmodule

`default_nettype wire

/* logic/tileStore.sv */
`timescale 1ns/1ps
`default_nettype none

module tileStore
	import tileCachePkg::*;
(
	input  wire logic                     clock,
	input  wire logic [tileIndexBits-1:0] readIndex,
	input  wire tileWrite_s               storeWrite,
	output tileLine_s                     readLine
);

	// separate arrays for data, tag and the two flag bits
	logic [tileDataBits-1:0] dataArray [tileLines];
	logic [tileTagBits-1:0]  tagArray  [tileLines];
	logic [1:0]              flagArray [tileLines];

	logic [tileDataBits-1:0] dataQ;
	logic [tileTagBits-1:0]  tagQ;
	logic [1:0]              flagQ;

	// write port, takes effect at the edge
	always_ff @(posedge clock)
	begin
		if (storeWrite.enable)
		begin
			dataArray[storeWrite.index] <= storeWrite.line.data;
			tagArray[storeWrite.index]  <= storeWrite.line.tag;
			flagArray[storeWrite.index] <= {storeWrite.line.valid, storeWrite.line.dirty};
		end
	end

	// registered read; same-index write in the same cycle gives old contents
	always_ff @(posedge clock)
	begin
		dataQ <= dataArray[readIndex];
		tagQ  <= tagArray[readIndex];
		flagQ <= flagArray[readIndex];
	end

	always_comb
	begin
		readLine.valid = flagQ[1];
		readLine.dirty = flagQ[0];
		readLine.tag   = tagQ;
		readLine.data  = dataQ;
	end

endmodule

`default_nettype wire

/* verification/ddrTileModel.sv */
`timescale 1ns/1ps
`default_nettype none

module ddrTileModel
	import tileCachePkg::*;
#(
	parameter logic [tileDataBits-1:0] fillMask = '0
)
(
	input  wire logic                    clock,
	input  wire logic                    reset,
	input  wire logic [addrBits-1:0]     ddrAddr,
	input  wire logic [tileDataBits-1:0] ddrDataOut,
	input  wire memOpm_e                 ddrOpm,
	output logic [tileDataBits-1:0]      ddrDataIn,
	output memOk_e                       ddrOk
);

	integer      seed = 32'h117f;
	int unsigned holdDraw;
	int unsigned holdLeft;

	// tiles written so far; everything else reads as the fill pattern
	logic [addrBits-1:0]     keptAddr [$];
	logic [tileDataBits-1:0] keptData [$];

	function automatic logic [tileDataBits-1:0] readTile(input logic [addrBits-1:0] addr);
		logic [tileDataBits-1:0] tile;
		tile = {4{addr}} ^ fillMask;
		foreach (keptAddr[i])
			if (keptAddr[i] == addr)
				tile = keptData[i];
		return tile;
	endfunction

	task automatic storeTile(input logic [addrBits-1:0] addr,
		input logic [tileDataBits-1:0] data);
		int slot;
		slot = -1;
		foreach (keptAddr[i])
			if (keptAddr[i] == addr)
				slot = i;
		if (slot < 0)
		begin
			keptAddr.push_back(addr);
			keptData.push_back(data);
		end
		else
			keptData[slot] = data;
	endtask

	task automatic completeAccess();
		ddrOk <= OK_OK;
		if (ddrOpm == OPM_RD_TILE)
			ddrDataIn <= readTile(ddrAddr);
		else
			storeTile(ddrAddr, ddrDataOut);
	endtask

	initial
	begin
		ddrOk     = OK_READY;
		ddrDataIn = '0;
	end

	// 0 to 5 HOLD cycles before each OK, then back to READY
	always @(posedge clock)
	begin
		if (reset)
		begin
			ddrOk    <= OK_READY;
			holdLeft <= 0;
		end
		else if (ddrOk == OK_OK)
			ddrOk <= OK_READY;
		else if ((ddrOk == OK_READY) && (ddrOpm != OPM_READY))
		begin
			holdDraw = $unsigned($random(seed)) % 6;
			if (holdDraw == 0)
				completeAccess();
			else
			begin
				ddrOk    <= OK_HOLD;
				holdLeft <= holdDraw - 1;
			end
		end
		else if (ddrOk == OK_HOLD)
		begin
			if (holdLeft == 0)
				completeAccess();
			else
				holdLeft <= holdLeft - 1;
		end
	end

endmodule

`default_nettype wire

/* verification/l2TileCacheTb.sv */
`timescale 1ns/1ps
`default_nettype none

module l2TileCacheTb
	import tileCachePkg::*;
();

	localparam int resetCycles    = 16;
	localparam int randomAccesses = 200;
	// 6 directed accesses ahead of the random run
	localparam int totalAccesses  = 6 + randomAccesses;
	localparam int watchdogCycles = totalAccesses * 200;
	localparam logic [tileDataBits-1:0] fillMask = 128'h3c5a_96e1_0ff0_a55a_c33c_5aa5_e187_7e81;

	logic                    clock;
	logic                    reset;
	logic [addrBits-1:0]     memAddr;
	logic [tileDataBits-1:0] memDataIn;
	memOpm_e                 memOpm;
	logic [tileDataBits-1:0] memDataOut;
	memOk_e                  memOk;
	logic [addrBits-1:0]     ddrAddr;
	logic [tileDataBits-1:0] ddrDataOut;
	memOpm_e                 ddrOpm;
	logic [tileDataBits-1:0] ddrDataIn;
	memOk_e                  ddrOk;

	int     errorCount;
	integer seed = 32'h117f;

	// reference tiles over 8 tags x 16 indices
	logic [tileDataBits-1:0] refData  [128];
	logic                    refValid [128];

	// last writeback seen on the DDR port
	int                      wbCount;
	logic [addrBits-1:0]     wbAddr;
	logic [tileDataBits-1:0] wbData;

	l2TileCache i_l2TileCache
	(
		.clock      (clock),
		.reset      (reset),
		.memAddr    (memAddr),
		.memDataIn  (memDataIn),
		.memOpm     (memOpm),
		.memDataOut (memDataOut),
		.memOk      (memOk),
		.ddrAddr    (ddrAddr),
		.ddrDataOut (ddrDataOut),
		.ddrOpm     (ddrOpm),
		.ddrDataIn  (ddrDataIn),
		.ddrOk      (ddrOk)
	);

	ddrTileModel #(.fillMask(fillMask)) i_ddrTileModel
	(
		.clock      (clock),
		.reset      (reset),
		.ddrAddr    (ddrAddr),
		.ddrDataOut (ddrDataOut),
		.ddrOpm     (ddrOpm),
		.ddrDataIn  (ddrDataIn),
		.ddrOk      (ddrOk)
	);

	always #10 clock = ~clock;

	always @(negedge clock)
	begin
		if ((ddrOpm == OPM_WR_TILE) && (ddrOk == OK_OK))
		begin
			wbCount = wbCount + 1;
			wbAddr  = ddrAddr;
			wbData  = ddrDataOut;
		end
	end

	function automatic logic [addrBits-1:0] tileAddress(input int tag, input int idx);
		return (tag << (tileIndexBits + tileOffsetBits)) | (idx << tileOffsetBits);
	endfunction

	// what the DDR side holds before anything is written
	function automatic logic [tileDataBits-1:0] initialTile(input logic [addrBits-1:0] addr);
		return {4{addr}} ^ fillMask;
	endfunction

	function automatic logic [tileDataBits-1:0] expectedTile(input int tag, input int idx);
		if (refValid[tag * 16 + idx])
			return refData[tag * 16 + idx];
		return initialTile(tileAddress(tag, idx));
	endfunction

	task automatic checkValue(input string name, input logic [tileDataBits-1:0] actual,
		input logic [tileDataBits-1:0] expected);
		if (actual !== expected)
		begin
			errorCount = errorCount + 1;
			$display("ERROR %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	// one access held until OK, followed by a READY cycle
	task automatic runAccess(input memOpm_e op, input logic [addrBits-1:0] addr,
		input logic [tileDataBits-1:0] data, output logic [tileDataBits-1:0] readData,
		output int cycles);
		@(posedge clock);
		memAddr   <= addr;
		memDataIn <= data;
		memOpm    <= op;
		cycles = 0;
		@(negedge clock);
		while (memOk != OK_OK)
		begin
			checkValue("memOk", memOk, OK_HOLD);
			@(negedge clock);
			cycles = cycles + 1;
		end
		readData = memDataOut;
		@(posedge clock);
		memOpm <= OPM_READY;
		@(negedge clock);
		checkValue("memOk", memOk, OK_READY);
	endtask

	task automatic writeTile(input int tag, input int idx, input logic [tileDataBits-1:0] data);
		logic [tileDataBits-1:0] unused;
		int                      cycles;
		runAccess(OPM_WR_TILE, tileAddress(tag, idx), data, unused, cycles);
		refData[tag * 16 + idx]  = data;
		refValid[tag * 16 + idx] = 1'b1;
	endtask

	task automatic readAndCompare(input int tag, input int idx, output int cycles);
		logic [tileDataBits-1:0] readData;
		runAccess(OPM_RD_TILE, tileAddress(tag, idx), '0, readData, cycles);
		checkValue("memDataOut", readData, expectedTile(tag, idx));
	endtask

	task automatic idleAfterReset();
		@(negedge clock);
		checkValue("memOk", memOk, OK_READY);
		checkValue("ddrOpm", ddrOpm, OPM_READY);
	endtask

	task automatic unwrittenTileRead();
		int cycles;
		readAndCompare(3, 7, cycles);
	endtask

	// the read hits and finishes in 2 cycles
	task automatic writeThenHit();
		int cycles;
		writeTile(4, 2, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210);
		readAndCompare(4, 2, cycles);
		checkValue("memOk cycles", cycles, 2);
	endtask

	task automatic dirtyEviction();
		logic [tileDataBits-1:0] dataA;
		int                      wbBefore;
		int                      cycles;
		dataA = 128'hdead_beef_0000_1111_2222_3333_4444_5555;
		writeTile(1, 9, dataA);
		wbBefore = wbCount;
		writeTile(6, 9, 128'h6666_7777_8888_9999_aaaa_bbbb_cccc_dddd);
		checkValue("writeback count", wbCount, wbBefore + 1);
		checkValue("ddrAddr", wbAddr, tileAddress(1, 9));
		checkValue("ddrDataOut", wbData, dataA);
		readAndCompare(1, 9, cycles);
	endtask

	task automatic randomTraffic();
		int                      n;
		int                      tag;
		int                      idx;
		int                      cycles;
		logic [tileDataBits-1:0] data;
		for (n = 0; n < randomAccesses; n = n + 1)
		begin
			tag = $unsigned($random(seed)) % 8;
			idx = $unsigned($random(seed)) % 16;
			if ($random(seed) & 1)
			begin
				data = {$random(seed), $random(seed), $random(seed), $random(seed)};
				writeTile(tag, idx, data);
			end
			else
				readAndCompare(tag, idx, cycles);
		end
	endtask

	initial
	begin
		clock      = 1'b0;
		reset      = 1'b1;
		memAddr    = '0;
		memDataIn  = '0;
		memOpm     = OPM_READY;
		errorCount = 0;
		wbCount    = 0;
		foreach (refValid[i])
			refValid[i] = 1'b0;
		repeat (resetCycles) @(posedge clock);
		reset <= 1'b0;

		idleAfterReset();
		unwrittenTileRead();
		writeThenHit();
		dirtyEviction();
		randomTraffic();

		$display("run complete, %0d check errors, %0d assertion failures", errorCount,
			i_l2TileCache.i_l2TileCache_sva.failureCount);
		if ((errorCount == 0) && (i_l2TileCache.i_l2TileCache_sva.failureCount == 0))
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		repeat (watchdogCycles) @(posedge clock);
		$display("timeout: the cache did not finish its accesses in %0d cycles", watchdogCycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/l2TileCache_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module l2TileCache_sva
	import tileCachePkg::*;
(
	input wire logic                clock,
	input wire logic                reset,
	input wire memOpm_e             memOpm,
	input wire memOk_e              memOk,
	input wire memOpm_e             ddrOpm,
	input wire memOk_e              ddrOk,
	input wire logic [addrBits-1:0] ddrAddr
);

	int failureCount = 0;

	// DDR request frozen during HOLD
	ddrHeldDuringHold: assert property (@(posedge clock) disable iff (reset)
		(ddrOk == OK_HOLD) |=> ($stable(ddrOpm) && $stable(ddrAddr)))
	else
	begin
		failureCount = failureCount + 1;
		$error("ddrOpm or ddrAddr changed while ddrOk was HOLD");
	end

	// OK only for a request that is held and not just issued
	noOkWhileIdle: assert property (@(posedge clock) disable iff (reset)
		(memOk == OK_OK) |-> ((memOpm != OPM_READY) && $stable(memOpm)))
	else
	begin
		failureCount = failureCount + 1;
		$error("memOk was OK while memOpm was READY or had just changed");
	end

	// a new DDR operation only starts from READY with the DDR side READY
	noRaiseWhileBusy: assert property (@(posedge clock) disable iff (reset)
		((ddrOpm != OPM_READY) && !$stable(ddrOpm))
			|-> (($past(ddrOpm) == OPM_READY) && ($past(ddrOk) == OK_READY)))
	else
	begin
		failureCount = failureCount + 1;
		$error("ddrOpm raised while ddrOk was not READY");
	end

endmodule

bind l2TileCache l2TileCache_sva i_l2TileCache_sva
(
	.clock   (clock),
	.reset   (reset),
	.memOpm  (memOpm),
	.memOk   (memOk),
	.ddrOpm  (ddrOpm),
	.ddrOk   (ddrOk),
	.ddrAddr (ddrAddr)
);

`default_nettype wire
